//--- audio_pkg.sv
package audio_pkg;

	// audio sample format
	localparam int sample_w = 16;

	// AXI4-Lite bus geometry
	localparam int axi_addr_w = 4;
	localparam int axi_data_w = 32;

	// register word addresses
	localparam logic [axi_addr_w-1:0] reg_ctrl = 4'd0;
	localparam logic [axi_addr_w-1:0] reg_latch = 4'd4;
	localparam logic [axi_addr_w-1:0] reg_status = 4'd8;
	localparam logic [axi_addr_w-1:0] reg_level = 4'd12;

	// control register bits
	localparam int ctrl_enable_bit = 0;
	localparam int ctrl_interp_bit = 1;

	// AXI response codes
	localparam logic [1:0] resp_okay = 2'd0;
	localparam logic [1:0] resp_slverr = 2'd2;

	// sample period measurement, saturates at the all-ones count
	localparam int period_w = 12;
	localparam logic [period_w-1:0] interp_limit = '1;

	// signed to offset binary for the DAC
	localparam logic [sample_w-1:0] dac_offset = 16'd32768;

endpackage

//--- audio_regs.sv
`timescale 1ns/1ps

module audio_regs (
	input  logic                                clk50,
	input  logic                                reset,
	input  logic [audio_pkg::axi_addr_w-1:0]    s_awaddr,
	input  logic                                s_awvalid,
	output logic                                s_awready,
	input  logic [audio_pkg::axi_data_w-1:0]    s_wdata,
	input  logic [audio_pkg::axi_data_w/8-1:0]  s_wstrb,
	input  logic                                s_wvalid,
	output logic                                s_wready,
	output logic [1:0]                          s_bresp,
	output logic                                s_bvalid,
	input  logic                                s_bready,
	input  logic [audio_pkg::axi_addr_w-1:0]    s_araddr,
	input  logic                                s_arvalid,
	output logic                                s_arready,
	output logic [audio_pkg::axi_data_w-1:0]    s_rdata,
	output logic [1:0]                          s_rresp,
	output logic                                s_rvalid,
	input  logic                                s_rready,
	input  logic                                sample_in,
	input  logic                                clear_irq,
	input  logic [audio_pkg::sample_w-1:0]      level_left,
	input  logic [audio_pkg::sample_w-1:0]      level_right,
	output logic                                enable,
	output logic                                interp_on,
	output logic [7:0]                          sound_latch,
	output logic                                irq
);
	import audio_pkg::*;

	logic wr_go;
	logic rd_go;
	logic wr_mapped;
	logic rd_mapped;
	logic ctrl_wr;
	logic latch_wr;
	logic [axi_data_w-1:0] rd_word;
	logic [15:0] sample_count;

	// both write channels must be present and the previous response taken
	assign wr_go = s_awvalid & s_wvalid & ~s_bvalid;
	assign s_awready = wr_go;
	assign s_wready = wr_go;

	// one read in flight at a time
	assign rd_go = s_arvalid & ~s_rvalid;
	assign s_arready = rd_go;

	assign wr_mapped = s_awaddr inside {reg_ctrl, reg_latch, reg_status, reg_level};
	assign rd_mapped = s_araddr inside {reg_ctrl, reg_latch, reg_status, reg_level};

	// only byte lane 0 carries anything writable
	assign ctrl_wr = wr_go && (s_awaddr == reg_ctrl) && s_wstrb[0];
	assign latch_wr = wr_go && (s_awaddr == reg_latch) && s_wstrb[0];

	// write response channel
	always_ff @(posedge clk50) begin
		if (reset) begin
			s_bvalid <= 1'b0;
		end else if (wr_go) begin
			s_bvalid <= 1'b1;
		end else if (s_bready) begin
			s_bvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk50) begin
		if (wr_go) begin
			s_bresp <= wr_mapped ? resp_okay : resp_slverr;
		end
	end

	// read data select, unmapped reads as zero
	always_comb begin
		rd_word = '0;
		case (s_araddr)
			reg_ctrl: begin
				rd_word[ctrl_enable_bit] = enable;
				rd_word[ctrl_interp_bit] = interp_on;
			end
			reg_latch: rd_word[7:0] = sound_latch;
			reg_status: rd_word = {sample_count, 15'd0, irq};
			reg_level: rd_word = {level_left, level_right};
			default: rd_word = '0;
		endcase
	end

	// read response channel, data captured at accept and held
	always_ff @(posedge clk50) begin
		if (reset) begin
			s_rvalid <= 1'b0;
		end else if (rd_go) begin
			s_rvalid <= 1'b1;
		end else if (s_rready) begin
			s_rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk50) begin
		if (rd_go) begin
			s_rdata <= rd_word;
			s_rresp <= rd_mapped ? resp_okay : resp_slverr;
		end
	end

	// control bits, sound latch and CPU interrupt
	always_ff @(posedge clk50) begin
		if (reset) begin
			enable <= 1'b0;
			interp_on <= 1'b0;
			sound_latch <= 8'd0;
			irq <= 1'b0;
		end else begin
			if (ctrl_wr) begin
				enable <= s_wdata[ctrl_enable_bit];
				interp_on <= s_wdata[ctrl_interp_bit];
			end
			// a new command beats the acknowledge
			if (latch_wr) begin
				sound_latch <= s_wdata[7:0];
				irq <= 1'b1;
			end else if (clear_irq) begin
				irq <= 1'b0;
			end
		end
	end

	// strobe counter, wraps
	always_ff @(posedge clk50) begin
		if (reset) begin
			sample_count <= 16'd0;
		end else if (sample_in) begin
			sample_count <= sample_count + 16'd1;
		end
	end

endmodule

//--- sample_interp.sv
`timescale 1ns/1ps

module sample_interp (
	input  logic                                  clk50,
	input  logic                                  reset,
	input  logic                                  sample_in,
	input  logic signed [audio_pkg::sample_w-1:0] left_in,
	input  logic signed [audio_pkg::sample_w-1:0] right_in,
	output logic                                  interp_valid,
	output logic signed [audio_pkg::sample_w-1:0] interp_left,
	output logic signed [audio_pkg::sample_w-1:0] interp_right
);
	import audio_pkg::*;

	logic [period_w-1:0] gap_count;
	logic [period_w-2:0] half_period;
	logic [period_w-2:0] wait_count;
	logic pending;
	logic signed [sample_w-1:0] last_left;
	logic signed [sample_w-1:0] last_right;
	logic signed [sample_w:0] sum_left;
	logic signed [sample_w:0] sum_right;
	logic signed [sample_w:0] mid_left;
	logic signed [sample_w:0] mid_right;

	// 17-bit sums so the average cannot overflow
	assign sum_left = last_left + left_in;
	assign sum_right = last_right + right_in;
	assign mid_left = sum_left >>> 1;
	assign mid_right = sum_right >>> 1;
	assign half_period = gap_count[period_w-1:1];

	always_ff @(posedge clk50) begin
		if (reset) begin
			// start saturated so the first strobe passes straight through
			gap_count <= interp_limit;
			wait_count <= '0;
			pending <= 1'b0;
			interp_valid <= 1'b0;
			last_left <= '0;
			last_right <= '0;
		end else begin
			interp_valid <= 1'b0;
			if (gap_count != interp_limit) begin
				gap_count <= gap_count + 1'b1;
			end
			if (sample_in) begin
				gap_count <= 1;
				last_left <= left_in;
				last_right <= right_in;
				interp_valid <= 1'b1;
				if (gap_count == interp_limit) begin
					interp_left <= left_in;
					interp_right <= right_in;
					pending <= 1'b0;
				end else begin
					interp_left <= mid_left[sample_w-1:0];
					interp_right <= mid_right[sample_w-1:0];
					pending <= 1'b1;
					// new sample lands half a period after the strobe
					wait_count <= (half_period > 2) ? half_period - 2'd2 : '0;
				end
			end else if (pending) begin
				if (wait_count == 0) begin
					interp_left <= last_left;
					interp_right <= last_right;
					interp_valid <= 1'b1;
					pending <= 1'b0;
				end else begin
					wait_count <= wait_count - 1'b1;
				end
			end
		end
	end

endmodule

//--- sigma_delta_dac.sv
`timescale 1ns/1ps

module sigma_delta_dac (
	input  logic                             clk50,
	input  logic                             reset,
	input  logic                             enable,
	input  logic [audio_pkg::sample_w-1:0]   level,
	output logic                             speaker
);
	import audio_pkg::*;

	logic [sample_w-1:0] level_unsigned;
	logic [sample_w-1:0] accum;
	logic [sample_w:0] sum;

	// two's complement to offset binary
	assign level_unsigned = level + dac_offset;
	assign sum = accum + level_unsigned;

	// carry out is the pulse density output
	always_ff @(posedge clk50) begin
		if (reset || !enable) begin
			accum <= '0;
			speaker <= 1'b0;
		end else begin
			accum <= sum[sample_w-1:0];
			speaker <= sum[sample_w];
		end
	end

endmodule

//--- audio_out_top.sv
`timescale 1ns/1ps

module audio_out_top (
	input  logic                                  clk50,
	input  logic                                  reset,
	input  logic [audio_pkg::axi_addr_w-1:0]      s_awaddr,
	input  logic                                  s_awvalid,
	output logic                                  s_awready,
	input  logic [audio_pkg::axi_data_w-1:0]      s_wdata,
	input  logic [audio_pkg::axi_data_w/8-1:0]    s_wstrb,
	input  logic                                  s_wvalid,
	output logic                                  s_wready,
	output logic [1:0]                            s_bresp,
	output logic                                  s_bvalid,
	input  logic                                  s_bready,
	input  logic [audio_pkg::axi_addr_w-1:0]      s_araddr,
	input  logic                                  s_arvalid,
	output logic                                  s_arready,
	output logic [audio_pkg::axi_data_w-1:0]      s_rdata,
	output logic [1:0]                            s_rresp,
	output logic                                  s_rvalid,
	input  logic                                  s_rready,
	input  logic                                  sample_in,
	input  logic signed [audio_pkg::sample_w-1:0] left_in,
	input  logic signed [audio_pkg::sample_w-1:0] right_in,
	output logic [7:0]                            sound_latch,
	output logic                                  irq,
	input  logic                                  clear_irq,
	output logic                                  speaker_left,
	output logic                                  speaker_right
);
	import audio_pkg::*;

	logic enable;
	logic interp_on;
	logic interp_valid;
	logic signed [sample_w-1:0] interp_left;
	logic signed [sample_w-1:0] interp_right;
	logic [sample_w-1:0] dac_left;
	logic [sample_w-1:0] dac_right;

	audio_regs i_audio_regs (
		.clk50       (clk50),
		.reset       (reset),
		.s_awaddr    (s_awaddr),
		.s_awvalid   (s_awvalid),
		.s_awready   (s_awready),
		.s_wdata     (s_wdata),
		.s_wstrb     (s_wstrb),
		.s_wvalid    (s_wvalid),
		.s_wready    (s_wready),
		.s_bresp     (s_bresp),
		.s_bvalid    (s_bvalid),
		.s_bready    (s_bready),
		.s_araddr    (s_araddr),
		.s_arvalid   (s_arvalid),
		.s_arready   (s_arready),
		.s_rdata     (s_rdata),
		.s_rresp     (s_rresp),
		.s_rvalid    (s_rvalid),
		.s_rready    (s_rready),
		.sample_in   (sample_in),
		.clear_irq   (clear_irq),
		.level_left  (dac_left),
		.level_right (dac_right),
		.enable      (enable),
		.interp_on   (interp_on),
		.sound_latch (sound_latch),
		.irq         (irq)
	);

	sample_interp i_sample_interp (
		.clk50        (clk50),
		.reset        (reset),
		.sample_in    (sample_in),
		.left_in      (left_in),
		.right_in     (right_in),
		.interp_valid (interp_valid),
		.interp_left  (interp_left),
		.interp_right (interp_right)
	);

	// DAC input register, direct or interpolated source
	always_ff @(posedge clk50) begin
		if (reset) begin
			dac_left <= '0;
			dac_right <= '0;
		end else if (interp_on) begin
			if (interp_valid) begin
				dac_left <= interp_left;
				dac_right <= interp_right;
			end
		end else if (sample_in) begin
			dac_left <= left_in;
			dac_right <= right_in;
		end
	end

	sigma_delta_dac i_dac_left (
		.clk50   (clk50),
		.reset   (reset),
		.enable  (enable),
		.level   (dac_left),
		.speaker (speaker_left)
	);

	sigma_delta_dac i_dac_right (
		.clk50   (clk50),
		.reset   (reset),
		.enable  (enable),
		.level   (dac_right),
		.speaker (speaker_right)
	);

endmodule

//--- audio_out_properties.sv
`timescale 1ns/1ps

module audio_out_properties (
	input logic                             clk50,
	input logic                             reset,
	input logic                             s_awready,
	input logic                             s_wready,
	input logic                             s_arready,
	input logic                             s_bvalid,
	input logic                             s_bready,
	input logic                             s_rvalid,
	input logic                             s_rready,
	input logic [audio_pkg::axi_data_w-1:0] s_rdata,
	input logic                             latch_wr,
	input logic                             irq
);

	// responses wait for the host
	bvalid_hold: assert property (@(posedge clk50) disable iff (reset)
		s_bvalid && !s_bready |=> s_bvalid)
		else $error("write response dropped before s_bready");

	rvalid_hold: assert property (@(posedge clk50) disable iff (reset)
		s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata))
		else $error("read response changed before s_rready");

	// only a command write raises the interrupt
	irq_source: assert property (@(posedge clk50) disable iff (reset)
		$rose(irq) |-> $past(latch_wr))
		else $error("irq rose without a latch write");

	awready_pulse: assert property (@(posedge clk50) disable iff (reset)
		s_awready |=> !s_awready)
		else $error("s_awready high for more than one cycle");

	wready_pulse: assert property (@(posedge clk50) disable iff (reset)
		s_wready |=> !s_wready)
		else $error("s_wready high for more than one cycle");

	arready_pulse: assert property (@(posedge clk50) disable iff (reset)
		s_arready |=> !s_arready)
		else $error("s_arready high for more than one cycle");

endmodule

bind audio_regs audio_out_properties i_audio_out_properties (
	.clk50     (clk50),
	.reset     (reset),
	.s_awready (s_awready),
	.s_wready  (s_wready),
	.s_arready (s_arready),
	.s_bvalid  (s_bvalid),
	.s_bready  (s_bready),
	.s_rvalid  (s_rvalid),
	.s_rready  (s_rready),
	.s_rdata   (s_rdata),
	.latch_wr  (latch_wr),
	.irq       (irq)
);

//--- tb_audio_out.sv
`timescale 1ns/1ps

module tb_audio_out;
	import audio_pkg::*;

	localparam int interp_period = 64;
	localparam int interp_strobes = 12;
	localparam int density_cycles = 65536;
	localparam int density_runs = 2;
	localparam int budget_cycles = density_runs * (density_cycles + 200)
		+ interp_strobes * interp_period + 10000;

	logic clk50 = 1'b0;
	logic reset;
	logic [axi_addr_w-1:0] s_awaddr;
	logic s_awvalid;
	logic s_awready;
	logic [axi_data_w-1:0] s_wdata;
	logic [axi_data_w/8-1:0] s_wstrb;
	logic s_wvalid;
	logic s_wready;
	logic [1:0] s_bresp;
	logic s_bvalid;
	logic s_bready;
	logic [axi_addr_w-1:0] s_araddr;
	logic s_arvalid;
	logic s_arready;
	logic [axi_data_w-1:0] s_rdata;
	logic [1:0] s_rresp;
	logic s_rvalid;
	logic s_rready;
	logic sample_in;
	logic [sample_w-1:0] left_in;
	logic [sample_w-1:0] right_in;
	logic [7:0] sound_latch;
	logic irq;
	logic clear_irq;
	logic speaker_left;
	logic speaker_right;

	logic [31:0] lfsr = 32'h46deeed7;
	int unsigned cycles = 0;

	// reference model state
	logic [1:0] model_ctrl = 2'b00;
	logic [7:0] model_latch = 8'd0;
	logic model_irq = 1'b0;
	logic [15:0] model_count = 16'd0;
	logic [15:0] prev_left = 16'd0;
	logic [15:0] prev_right = 16'd0;
	logic [15:0] last_left = 16'd0;
	logic [15:0] last_right = 16'd0;

	audio_out_top i_audio_out_top (
		.clk50         (clk50),
		.reset         (reset),
		.s_awaddr      (s_awaddr),
		.s_awvalid     (s_awvalid),
		.s_awready     (s_awready),
		.s_wdata       (s_wdata),
		.s_wstrb       (s_wstrb),
		.s_wvalid      (s_wvalid),
		.s_wready      (s_wready),
		.s_bresp       (s_bresp),
		.s_bvalid      (s_bvalid),
		.s_bready      (s_bready),
		.s_araddr      (s_araddr),
		.s_arvalid     (s_arvalid),
		.s_arready     (s_arready),
		.s_rdata       (s_rdata),
		.s_rresp       (s_rresp),
		.s_rvalid      (s_rvalid),
		.s_rready      (s_rready),
		.sample_in     (sample_in),
		.left_in       (left_in),
		.right_in      (right_in),
		.sound_latch   (sound_latch),
		.irq           (irq),
		.clear_irq     (clear_irq),
		.speaker_left  (speaker_left),
		.speaker_right (speaker_right)
	);

	always #50 clk50 = ~clk50;

	always @(posedge clk50) begin
		cycles <= cycles + 1;
	end

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		repeat (n) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// signed average with arithmetic shift
	function automatic logic [15:0] average(input logic [15:0] a, input logic [15:0] b);
		logic signed [16:0] sum;
		sum = $signed({a[15], a}) + $signed({b[15], b});
		return sum[16:1];
	endfunction

	task automatic check(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("ERROR at %0t: %s, expected %h, got %h", $time, what, expected, actual);
			$display("TEST FAILED");
			$fatal(1, "mismatch in %s", what);
		end
	endtask

	// called on a falling edge, returns on a falling edge
	task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
			input logic [3:0] strb, input logic with_clear, output logic [1:0] resp);
		int delay;
		s_awaddr = addr;
		s_wdata = data;
		s_wstrb = strb;
		s_awvalid = 1'b1;
		s_wvalid = 1'b1;
		clear_irq = with_clear;
		#10;
		while (!s_awready) begin
			@(negedge clk50);
			#10;
		end
		check(s_wready, 1'b1, "s_wready with s_awready");
		@(negedge clk50);
		s_awvalid = 1'b0;
		s_wvalid = 1'b0;
		clear_irq = 1'b0;
		while (!s_bvalid) @(negedge clk50);
		resp = s_bresp;
		delay = rand_bits(2);
		repeat (delay) @(negedge clk50);
		s_bready = 1'b1;
		@(negedge clk50);
		s_bready = 1'b0;
	endtask

	task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		int delay;
		s_araddr = addr;
		s_arvalid = 1'b1;
		#10;
		while (!s_arready) begin
			@(negedge clk50);
			#10;
		end
		@(negedge clk50);
		s_arvalid = 1'b0;
		while (!s_rvalid) @(negedge clk50);
		data = s_rdata;
		resp = s_rresp;
		delay = rand_bits(2);
		repeat (delay) @(negedge clk50);
		s_rready = 1'b1;
		@(negedge clk50);
		s_rready = 1'b0;
	endtask

	task automatic strobe(input logic [15:0] left, input logic [15:0] right);
		sample_in = 1'b1;
		left_in = left;
		right_in = right;
		@(negedge clk50);
		sample_in = 1'b0;
		prev_left = last_left;
		prev_right = last_right;
		last_left = left;
		last_right = right;
		model_count = model_count + 16'd1;
	endtask

	task automatic write_ctrl(input logic [1:0] value);
		logic [1:0] resp;
		axi_write(reg_ctrl, {30'd0, value}, 4'hf, 1'b0, resp);
		check(resp, resp_okay, "control write response");
		model_ctrl = value;
	endtask

	task automatic check_density(input int ones, input logic [15:0] level, input string what);
		logic [15:0] level_unsigned;
		int diff;
		level_unsigned = level + dac_offset;
		diff = ones - int'(level_unsigned);
		check(diff >= -1 && diff <= 1, 1, what);
	endtask

	initial begin
		repeat (budget_cycles) @(posedge clk50);
		$display("watchdog: simulation timed out after %0d cycles", budget_cycles);
		$display("TEST FAILED");
		$fatal(1, "timeout");
	end

	initial begin
		logic [1:0] resp;
		logic [31:0] data;
		logic [3:0] strb;
		logic [3:0] addr;
		logic [15:0] level;
		int n;
		int k;
		int t0;
		int ones_left;
		int ones_right;
		reset = 1'b1;
		s_awaddr = '0;
		s_awvalid = 1'b0;
		s_wdata = '0;
		s_wstrb = '0;
		s_wvalid = 1'b0;
		s_bready = 1'b0;
		s_araddr = '0;
		s_arvalid = 1'b0;
		s_rready = 1'b0;
		sample_in = 1'b0;
		left_in = '0;
		right_in = '0;
		clear_irq = 1'b0;
		repeat (5) @(negedge clk50);
		reset = 1'b0;
		@(negedge clk50);
		check({s_awready, s_wready, s_arready, s_bvalid, s_rvalid, irq,
			speaker_left, speaker_right}, 0, "outputs after reset");
		check(sound_latch, 0, "sound latch after reset");
		axi_read(reg_ctrl, data, resp);
		check(data, 0, "control after reset");

		// control readback, byte strobes and unmapped addresses
		repeat (8) begin
			data = rand_bits(32);
			strb = rand_bits(4);
			axi_write(reg_ctrl, data, strb, 1'b0, resp);
			check(resp, resp_okay, "control write response");
			if (strb[0])
				model_ctrl = data[1:0];
			axi_read(reg_ctrl, data, resp);
			check(resp, resp_okay, "control read response");
			check(data, {30'd0, model_ctrl}, "control readback");
			addr = rand_bits(4);
			if (addr[1:0] == 2'b00)
				addr[0] = 1'b1;
			axi_write(addr, rand_bits(32), 4'hf, 1'b0, resp);
			check(resp, resp_slverr, "unmapped write response");
			axi_read(addr, data, resp);
			check(resp, resp_slverr, "unmapped read response");
			check(data, 0, "unmapped read data");
		end
		check(sound_latch, model_latch, "latch untouched by other writes");

		// sound latch and interrupt
		data = rand_bits(32);
		axi_write(reg_latch, data, 4'h1, 1'b0, resp);
		check(resp, resp_okay, "latch write response");
		model_latch = data[7:0];
		model_irq = 1'b1;
		check(sound_latch, model_latch, "sound latch after write");
		check(irq, model_irq, "irq after latch write");
		axi_read(reg_latch, data, resp);
		check(data, {24'd0, model_latch}, "latch readback");
		axi_read(reg_status, data, resp);
		check(data[0], 1'b1, "status irq bit set");
		clear_irq = 1'b1;
		@(negedge clk50);
		clear_irq = 1'b0;
		model_irq = 1'b0;
		check(irq, model_irq, "irq after clear");
		axi_read(reg_status, data, resp);
		check(data[0], 1'b0, "status irq bit cleared");
		// write and acknowledge in the same cycle
		data = rand_bits(32);
		axi_write(reg_latch, data, 4'h1, 1'b1, resp);
		model_latch = data[7:0];
		model_irq = 1'b1;
		check(irq, model_irq, "latch write beats clear");
		check(sound_latch, model_latch, "sound latch after second write");
		clear_irq = 1'b1;
		@(negedge clk50);
		clear_irq = 1'b0;
		model_irq = 1'b0;

		// strobe counter
		n = rand_bits(4) + 1;
		repeat (n) begin
			strobe(rand_bits(16), rand_bits(16));
			repeat (rand_bits(3)) @(negedge clk50);
		end
		axi_read(reg_status, data, resp);
		check(data[31:16], model_count, "strobe count");
		check(data[15:0], {15'd0, model_irq}, "status low half");

		// direct path
		write_ctrl(2'b01);
		repeat (8) begin
			strobe(rand_bits(16), rand_bits(16));
			repeat (rand_bits(3)) @(negedge clk50);
			axi_read(reg_level, data, resp);
			check(data, {last_left, last_right}, "direct level");
		end

		// interpolation, first strobe only primes the period
		write_ctrl(2'b11);
		for (k = 0; k < interp_strobes; k++) begin
			t0 = cycles;
			strobe(rand_bits(16), rand_bits(16));
			while (cycles - t0 < 4) @(negedge clk50);
			axi_read(reg_level, data, resp);
			if (k > 0)
				check(data, {average(prev_left, last_left), average(prev_right, last_right)},
					"interpolated midpoint");
			while (cycles - t0 < interp_period * 3 / 4) @(negedge clk50);
			axi_read(reg_level, data, resp);
			if (k > 0)
				check(data, {last_left, last_right}, "interpolated new sample");
			while (cycles - t0 < interp_period) @(negedge clk50);
		end

		// pulse density at a constant level
		write_ctrl(2'b00);
		repeat (density_runs) begin
			level = rand_bits(16);
			strobe(level, ~level);
			write_ctrl(2'b01);
			repeat (2) @(negedge clk50);
			ones_left = 0;
			ones_right = 0;
			repeat (density_cycles) begin
				@(negedge clk50);
				ones_left += speaker_left;
				ones_right += speaker_right;
			end
			check_density(ones_left, level, "left speaker density");
			check_density(ones_right, ~level, "right speaker density");
			write_ctrl(2'b00);
		end
		repeat (2) @(negedge clk50);
		ones_left = 0;
		repeat (256) begin
			@(negedge clk50);
			ones_left += speaker_left + speaker_right;
		end
		check(ones_left, 0, "speakers low while disabled");

		$display("TEST OK");
		$finish;
	end

endmodule

//--- files.f
audio_pkg.sv
audio_regs.sv
sample_interp.sv
sigma_delta_dac.sv
audio_out_top.sv
audio_out_properties.sv
tb_audio_out.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the audio output testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f files.f \
	--top-module tb_audio_out -o sim_audio_out

./obj_dir/sim_audio_out | tee sim.log

if grep -q "^TEST OK$" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
